// File: common/fhe_alu_pkg.sv
package fhe_alu_pkg;

  // data word and command field widths
  localparam int FSIZE = 32;
  localparam int CMD_WIDTH = 4;
  localparam int MODE_WIDTH = 2;

  // host commands
  // W: data0 = W, data1 = WQ
  localparam logic [CMD_WIDTH-1:0] COMMAND_IBUTTER_W = 4'd1;
  // P: data0 = modulus
  localparam logic [CMD_WIDTH-1:0] COMMAND_IBUTTER_P = 4'd2;
  // A: data0 = a, data1 = b, starts a butterfly
  localparam logic [CMD_WIDTH-1:0] COMMAND_IBUTTER_A = 4'd3;
  // SCALAR: data0 = a, starts a scalar multiply
  localparam logic [CMD_WIDTH-1:0] COMMAND_IBUTTER_SCALAR = 4'd4;

  // engine state, reported on stateport0
  localparam logic [FSIZE-1:0] STATE_IDLE = 32'd0;
  localparam logic [FSIZE-1:0] STATE_RUNNING = 32'd1;
  localparam logic [FSIZE-1:0] STATE_RUNNING_SCALAR = 32'd2;
  localparam logic [FSIZE-1:0] STATE_WAIT = 32'd3;

  // butterfly issue mode
  localparam logic [MODE_WIDTH-1:0] MODE_NONE = 2'd0;
  localparam logic [MODE_WIDTH-1:0] MODE_BUTTERFLY = 2'd1;
  localparam logic [MODE_WIDTH-1:0] MODE_SCALAR = 2'd2;

endpackage

// File: common/cmd_if.sv
`timescale 1ns/100ps

interface cmd_if import fhe_alu_pkg::*; ();

  // plain strobe, one command per cycle while valid is high
  logic valid;
  logic [CMD_WIDTH-1:0] command;
  logic [FSIZE-1:0] data0;
  logic [FSIZE-1:0] data1;

  modport host (
    output valid,
    output command,
    output data0,
    output data1
  );

  modport engine (
    input valid,
    input command,
    input data0,
    input data1
  );

endinterface

// File: fhe_intt/shoup_mulmod.sv
`timescale 1ns/100ps

module shoup_mulmod import fhe_alu_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic in_valid,
  input  logic [FSIZE-1:0] x,
  input  logic [FSIZE-1:0] W,
  input  logic [FSIZE-1:0] WQ,
  input  logic [FSIZE-1:0] p,
  output logic [FSIZE-1:0] r,
  output logic out_valid
);

  logic [FSIZE-1:0] xw;
  logic [2*FSIZE-1:0] xwq;
  logic [FSIZE-1:0] lo_r;
  logic [FSIZE-1:0] q_r;
  logic [FSIZE-1:0] p_r;
  logic [FSIZE-1:0] qp;
  logic [FSIZE-1:0] t;
  logic [FSIZE-1:0] r_reg;
  logic [1:0] vld;

  // low word of x * W is all that stage two needs
  assign xw = x * W;
  assign xwq = {{FSIZE{1'b0}}, x} * {{FSIZE{1'b0}}, WQ};

  // quotient estimate is off by at most one, so t lies in [0, 2p)
  assign qp = q_r * p_r;
  assign t = lo_r - qp;

  always_ff @(posedge clk) begin
    lo_r <= xw;
    q_r <= xwq[2*FSIZE-1:FSIZE];
    p_r <= p;
    r_reg <= (t >= p_r) ? t - p_r : t;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld <= 2'b00;
    end else begin
      vld <= {vld[0], in_valid};
    end
  end

  assign r = r_reg;
  assign out_valid = vld[1];

endmodule

// File: fhe_intt/ibutt.sv
`timescale 1ns/100ps

module ibutt import fhe_alu_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic [MODE_WIDTH-1:0] in_mode,
  input  logic [FSIZE-1:0] a,
  input  logic [FSIZE-1:0] b,
  input  logic [FSIZE-1:0] p,
  input  logic [FSIZE-1:0] W,
  input  logic [FSIZE-1:0] WQ,
  output logic [FSIZE-1:0] a_out,
  output logic [FSIZE-1:0] b_out,
  output logic out_valid
);

  logic [FSIZE-1:0] sum_raw;
  logic [FSIZE-1:0] sum_mod;
  logic [FSIZE-1:0] diff_mod;

  logic s1_valid;
  logic [MODE_WIDTH-1:0] s1_mode;
  logic [MODE_WIDTH-1:0] s2_mode;
  logic [MODE_WIDTH-1:0] s3_mode;
  logic [FSIZE-1:0] s1_sum;
  logic [FSIZE-1:0] s2_sum;
  logic [FSIZE-1:0] s3_sum;
  logic [FSIZE-1:0] s1_x;
  logic [FSIZE-1:0] s1_w;
  logic [FSIZE-1:0] s1_wq;
  logic [FSIZE-1:0] s1_p;
  logic [FSIZE-1:0] prod;

  // a, b < p < 2^30 so the sum never wraps
  assign sum_raw = a + b;
  assign sum_mod = (sum_raw >= p) ? sum_raw - p : sum_raw;
  assign diff_mod = (a >= b) ? a - b : a + p - b;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= (in_mode != MODE_NONE);
    end
  end

  // stage one, parameters travel with the operand
  always_ff @(posedge clk) begin
    s1_mode <= in_mode;
    s1_sum <= sum_mod;
    s1_x <= (in_mode == MODE_SCALAR) ? a : diff_mod;
    s1_w <= W;
    s1_wq <= WQ;
    s1_p <= p;
    s2_mode <= s1_mode;
    s2_sum <= s1_sum;
    s3_mode <= s2_mode;
    s3_sum <= s2_sum;
  end

  shoup_mulmod mul0 (
    .clk(clk),
    .rstn(rstn),
    .in_valid(s1_valid),
    .x(s1_x),
    .W(s1_w),
    .WQ(s1_wq),
    .p(s1_p),
    .r(prod),
    .out_valid(out_valid)
  );

  // scalar mode returns the product on a_out
  assign a_out = (s3_mode == MODE_SCALAR) ? prod : s3_sum;
  assign b_out = (s3_mode == MODE_SCALAR) ? '0 : prod;

endmodule

// File: fhe_intt/fhe_intt.sv
`timescale 1ns/100ps

module fhe_intt import fhe_alu_pkg::*; (
  input  logic clk,
  input  logic rstn,
  cmd_if.engine cmd,
  output logic [FSIZE-1:0] stateport0,
  output logic [FSIZE-1:0] stateport1,
  output logic [FSIZE-1:0] stateport2
);

  logic [FSIZE-1:0] state;
  logic [FSIZE-1:0] w_reg;
  logic [FSIZE-1:0] wq_reg;
  logic [FSIZE-1:0] p_reg;
  logic [FSIZE-1:0] a_reg;
  logic [FSIZE-1:0] b_reg;
  logic [FSIZE-1:0] a_out_reg;
  logic [FSIZE-1:0] b_out_reg;

  logic [MODE_WIDTH-1:0] in_mode;
  logic [FSIZE-1:0] butt_a_out;
  logic [FSIZE-1:0] butt_b_out;
  logic butt_out_valid;

  logic cmd_w;
  logic cmd_p;
  logic cmd_a;
  logic cmd_scalar;

  // command decode
  assign cmd_w = cmd.valid && (cmd.command == COMMAND_IBUTTER_W);
  assign cmd_p = cmd.valid && (cmd.command == COMMAND_IBUTTER_P);
  assign cmd_a = cmd.valid && (cmd.command == COMMAND_IBUTTER_A);
  assign cmd_scalar = cmd.valid && (cmd.command == COMMAND_IBUTTER_SCALAR);

  ibutt ibutt0 (
    .clk(clk),
    .rstn(rstn),
    .in_mode(in_mode),
    .a(a_reg),
    .b(b_reg),
    .p(p_reg),
    .W(w_reg),
    .WQ(wq_reg),
    .a_out(butt_a_out),
    .b_out(butt_b_out),
    .out_valid(butt_out_valid)
  );

  // operand and parameter registers
  always_ff @(posedge clk) begin
    if (cmd_w) begin
      w_reg <= cmd.data0;
      wq_reg <= cmd.data1;
    end
    if (cmd_p) begin
      p_reg <= cmd.data0;
    end
    if (cmd_a) begin
      a_reg <= cmd.data0;
      b_reg <= cmd.data1;
    end else if (cmd_scalar) begin
      a_reg <= cmd.data0;
      b_reg <= '0;
    end
  end

  // issue FSM, one operation in flight at a time
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= STATE_IDLE;
      in_mode <= MODE_NONE;
      a_out_reg <= '0;
      b_out_reg <= '0;
    end else begin
      in_mode <= MODE_NONE;
      case (state)
        STATE_RUNNING: begin
          in_mode <= MODE_BUTTERFLY;
          state <= STATE_WAIT;
        end
        STATE_RUNNING_SCALAR: begin
          in_mode <= MODE_SCALAR;
          state <= STATE_WAIT;
        end
        STATE_WAIT: begin
          if (butt_out_valid) begin
            a_out_reg <= butt_a_out;
            b_out_reg <= butt_b_out;
            state <= STATE_IDLE;
          end
        end
        default: begin
        end
      endcase
      // a new operand command restarts the sequence
      if (cmd_a) begin
        state <= STATE_RUNNING;
      end else if (cmd_scalar) begin
        state <= STATE_RUNNING_SCALAR;
      end
    end
  end

  assign stateport0 = state;
  assign stateport1 = a_out_reg;
  assign stateport2 = b_out_reg;

endmodule

// File: verilog/fhe_alu_top.sv
`timescale 1ns/100ps

module fhe_alu_top import fhe_alu_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic cmd_valid,
  input  logic [CMD_WIDTH-1:0] cmd_code,
  input  logic [FSIZE-1:0] cmd_data0,
  input  logic [FSIZE-1:0] cmd_data1,
  output logic [FSIZE-1:0] stateport0,
  output logic [FSIZE-1:0] stateport1,
  output logic [FSIZE-1:0] stateport2
);

  cmd_if cmd0 ();

  // host side of the command bus
  assign cmd0.valid = cmd_valid;
  assign cmd0.command = cmd_code;
  assign cmd0.data0 = cmd_data0;
  assign cmd0.data1 = cmd_data1;

  fhe_intt intt0 (
    .clk(clk),
    .rstn(rstn),
    .cmd(cmd0.engine),
    .stateport0(stateport0),
    .stateport1(stateport1),
    .stateport2(stateport2)
  );

endmodule

// File: verification/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference arithmetic, straight from the modular definitions

function automatic logic [FSIZE-1:0] add_mod(input logic [FSIZE-1:0] x,
                                             input logic [FSIZE-1:0] y,
                                             input logic [FSIZE-1:0] p);
  logic [FSIZE:0] s;
  s = ({1'b0, x} + {1'b0, y}) % {1'b0, p};
  return s[FSIZE-1:0];
endfunction

// x - y kept non-negative by adding p first
function automatic logic [FSIZE-1:0] sub_mod(input logic [FSIZE-1:0] x,
                                             input logic [FSIZE-1:0] y,
                                             input logic [FSIZE-1:0] p);
  logic [FSIZE:0] s;
  s = ({1'b0, x} + {1'b0, p} - {1'b0, y}) % {1'b0, p};
  return s[FSIZE-1:0];
endfunction

function automatic logic [FSIZE-1:0] mul_mod(input logic [FSIZE-1:0] x,
                                             input logic [FSIZE-1:0] w,
                                             input logic [FSIZE-1:0] p);
  logic [2*FSIZE-1:0] prod;
  prod = ({{FSIZE{1'b0}}, x} * {{FSIZE{1'b0}}, w}) % {{FSIZE{1'b0}}, p};
  return prod[FSIZE-1:0];
endfunction

// floor(w * 2^32 / p), fits one word since w < p
function automatic logic [FSIZE-1:0] twiddle_quotient(input logic [FSIZE-1:0] w,
                                                      input logic [FSIZE-1:0] p);
  logic [2*FSIZE-1:0] q;
  q = {w, {FSIZE{1'b0}}} / {{FSIZE{1'b0}}, p};
  return q[FSIZE-1:0];
endfunction

`endif

// File: verification/tb_fhe_alu.sv
`timescale 1ns/100ps

module tb_fhe_alu import fhe_alu_pkg::*; ();

  localparam int NUM_VEC = 12;
  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DELAY = 10;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_TIMEOUT = 50;
  localparam int OP_LATENCY = 5;
  localparam logic [FSIZE-1:0] BIG_P = 32'h3fff_fffd;

  logic clk;
  logic rstn;
  logic cmd_valid;
  logic [CMD_WIDTH-1:0] cmd_code;
  logic [FSIZE-1:0] cmd_data0;
  logic [FSIZE-1:0] cmd_data1;
  logic [FSIZE-1:0] stateport0;
  logic [FSIZE-1:0] stateport1;
  logic [FSIZE-1:0] stateport2;

  // vector table
  logic [MODE_WIDTH-1:0] vec_mode [NUM_VEC];
  logic vec_send [NUM_VEC];
  logic [FSIZE-1:0] vec_p [NUM_VEC];
  logic [FSIZE-1:0] vec_w [NUM_VEC];
  logic [FSIZE-1:0] vec_a [NUM_VEC];
  logic [FSIZE-1:0] vec_b [NUM_VEC];
  logic [FSIZE-1:0] vec_exp_a [NUM_VEC];
  logic [FSIZE-1:0] vec_exp_b [NUM_VEC];

  integer seed;
  int checks;
  int mismatches;
  int timeouts;

  `include "tb_model.svh"

  fhe_alu_top dut0 (
    .clk(clk),
    .rstn(rstn),
    .cmd_valid(cmd_valid),
    .cmd_code(cmd_code),
    .cmd_data0(cmd_data0),
    .cmd_data1(cmd_data1),
    .stateport0(stateport0),
    .stateport1(stateport1),
    .stateport2(stateport2)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic check_value(input string name, input logic [FSIZE-1:0] actual,
                             input logic [FSIZE-1:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
      mismatches++;
    end
  endtask

  task automatic set_vector(input int i, input logic [MODE_WIDTH-1:0] mode, input logic send,
                            input logic [FSIZE-1:0] p, input logic [FSIZE-1:0] w,
                            input logic [FSIZE-1:0] a, input logic [FSIZE-1:0] b);
    vec_mode[i] = mode;
    vec_send[i] = send;
    vec_p[i] = p;
    vec_w[i] = w;
    vec_a[i] = a;
    vec_b[i] = b;
  endtask

  task automatic build_vectors();
    logic [FSIZE-1:0] p;
    logic [FSIZE-1:0] w;
    logic [FSIZE-1:0] a;
    logic [FSIZE-1:0] b;
    int i;
    // small modulus, a < b then a >= b with W and p reused
    set_vector(0, MODE_BUTTERFLY, 1'b1, 32'd17, 32'd3, 32'd5, 32'd9);
    set_vector(1, MODE_BUTTERFLY, 1'b0, 32'd17, 32'd3, 32'd12, 32'd4);
    set_vector(2, MODE_BUTTERFLY, 1'b1, 32'd17, 32'd1, 32'd16, 32'd16);
    // near the modulus limit
    set_vector(3, MODE_BUTTERFLY, 1'b1, BIG_P, BIG_P - 1, BIG_P - 1, 32'd0);
    set_vector(4, MODE_BUTTERFLY, 1'b0, BIG_P, BIG_P - 1, 32'd0, BIG_P - 1);
    set_vector(5, MODE_SCALAR, 1'b1, BIG_P, 32'h1234_5678, BIG_P - 1, 32'd0);
    set_vector(6, MODE_SCALAR, 1'b0, BIG_P, 32'h1234_5678, 32'd0, 32'd0);
    set_vector(7, MODE_SCALAR, 1'b1, 32'd97, 32'd1, 32'd96, 32'd0);
    for (i = 8; i < NUM_VEC; i++) begin
      p = {$random(seed)} & 32'h3fff_ffff;
      if (p < 32'd3) begin
        p = 32'd3;
      end
      w = {$random(seed)} % p;
      a = {$random(seed)} % p;
      b = {$random(seed)} % p;
      if (i % 2 == 0) begin
        set_vector(i, MODE_BUTTERFLY, 1'b1, p, w, a, b);
      end else begin
        set_vector(i, MODE_SCALAR, 1'b1, p, w, a, 32'd0);
      end
    end
    for (i = 0; i < NUM_VEC; i++) begin
      if (vec_mode[i] == MODE_SCALAR) begin
        vec_exp_a[i] = mul_mod(vec_a[i], vec_w[i], vec_p[i]);
        vec_exp_b[i] = '0;
      end else begin
        vec_exp_a[i] = add_mod(vec_a[i], vec_b[i], vec_p[i]);
        vec_exp_b[i] = mul_mod(sub_mod(vec_a[i], vec_b[i], vec_p[i]), vec_w[i], vec_p[i]);
      end
    end
  endtask

  // one strobe, returns just after the edge that samples it
  task automatic send_cmd(input logic [CMD_WIDTH-1:0] code, input logic [FSIZE-1:0] d0,
                          input logic [FSIZE-1:0] d1);
    cmd_valid = 1'b1;
    cmd_code = code;
    cmd_data0 = d0;
    cmd_data1 = d1;
    @(posedge clk);
    #DRIVE_DELAY;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle(output int edges);
    edges = 0;
    while (stateport0 !== STATE_IDLE && edges < IDLE_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      edges++;
    end
    if (stateport0 !== STATE_IDLE) begin
      $display("timeout: engine did not return to idle within %0d cycles", IDLE_TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic run_vector(input int i);
    logic [FSIZE-1:0] run_state;
    logic [FSIZE-1:0] prev_a;
    logic [FSIZE-1:0] prev_b;
    int edges;
    prev_a = (i > 0) ? vec_exp_a[i-1] : '0;
    prev_b = (i > 0) ? vec_exp_b[i-1] : '0;
    if (vec_send[i]) begin
      send_cmd(COMMAND_IBUTTER_W, vec_w[i], twiddle_quotient(vec_w[i], vec_p[i]));
      send_cmd(COMMAND_IBUTTER_P, vec_p[i], '0);
      // new parameters must not disturb the held results
      check_value("stateport0", stateport0, STATE_IDLE);
      check_value("stateport1", stateport1, prev_a);
      check_value("stateport2", stateport2, prev_b);
    end
    if (vec_mode[i] == MODE_SCALAR) begin
      send_cmd(COMMAND_IBUTTER_SCALAR, vec_a[i], '0);
      run_state = STATE_RUNNING_SCALAR;
    end else begin
      send_cmd(COMMAND_IBUTTER_A, vec_a[i], vec_b[i]);
      run_state = STATE_RUNNING;
    end
    check_value("stateport0", stateport0, run_state);
    wait_idle(edges);
    check_value("latency", edges, OP_LATENCY);
    check_value("stateport1", stateport1, vec_exp_a[i]);
    check_value("stateport2", stateport2, vec_exp_b[i]);
  endtask

  initial begin
    seed = 69;
    checks = 0;
    mismatches = 0;
    timeouts = 0;
    rstn = 1'b0;
    cmd_valid = 1'b0;
    cmd_code = '0;
    cmd_data0 = '0;
    cmd_data1 = '0;
    build_vectors();

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rstn = 1'b1;
    check_value("stateport0", stateport0, STATE_IDLE);
    check_value("stateport1", stateport1, '0);
    check_value("stateport2", stateport2, '0);

    for (int i = 0; i < NUM_VEC; i++) begin
      run_vector(i);
    end

    $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verification
common/fhe_alu_pkg.sv
common/cmd_if.sv
fhe_intt/shoup_mulmod.sv
fhe_intt/ibutt.sv
fhe_intt/fhe_intt.sv
verilog/fhe_alu_top.sv
verification/tb_fhe_alu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
  --top-module tb_fhe_alu --Mdir obj_dir -o sim_fhe_alu
./obj_dir/sim_fhe_alu > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
